/* hdl/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// buffer geometry
`define ROB_DEPTH 16
`define ROB_TAG_W 4 // log2 of ROB_DEPTH

// word widths
`define XLEN 32
`define REG_W 5
`define OPC_W 7 // RV32I major opcode field

`endif

/* hdl/robPkg.sv */
`include "rob_settings.svh"

package robPkg;

    typedef logic [`ROB_TAG_W-1:0] robTag_t; // slot index
    typedef logic [`REG_W-1:0] regName_t;
    typedef logic [`XLEN-1:0] data_t;
    typedef logic [`XLEN-1:0] addr_t;

    // major opcodes that change the entry kind
    localparam logic [`OPC_W-1:0] OP_STORE = 7'b0100011;
    localparam logic [`OPC_W-1:0] OP_BRANCH = 7'b1100011;
    localparam logic [`OPC_W-1:0] OP_JAL = 7'b1101111;
    localparam logic [`OPC_W-1:0] OP_JALR = 7'b1100111;

endpackage

/* hdl/robDispatch.sv */
`include "rob_settings.svh"

module robDispatch (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dispReq,
    input  logic [`OPC_W-1:0]      dispOpcode,
    input  robPkg::regName_t       dispRd,
    input  logic                   dispPredTaken,
    input  logic                   full,
    input  logic                   flushNow,
    input  robPkg::robTag_t        tailTag,
    output logic                   dispOk,
    output robPkg::robTag_t        dispTag,
    output logic                   allocEn,
    output logic                   allocIsStore,
    output logic                   allocIsBranch,
    output robPkg::regName_t       allocRd,
    output logic                   allocPred
);
    import robPkg::*;

    logic isStore;
    logic isCondBranch;
    logic isJump;

    // opcode classification
    assign isStore = (dispOpcode == OP_STORE);
    assign isCondBranch = (dispOpcode == OP_BRANCH);
    assign isJump = (dispOpcode == OP_JAL) || (dispOpcode == OP_JALR);

    // grant while there is room and no flush is being decided
    assign dispOk = dispReq && !full && !flushNow;
    assign dispTag = tailTag; // tags come out in order

    assign allocEn = dispOk;
    assign allocIsStore = isStore;
    assign allocIsBranch = isCondBranch || isJump; // jal/jalr still carry a link rd
    assign allocPred = dispPredTaken;

    // only register-writing instructions keep their rd
    always_comb begin
        if (isStore || isCondBranch) begin
            allocRd = '0;
        end else begin
            allocRd = dispRd;
        end
    end

    // every grant moves the core's tail on by one slot
    tailAdvance: assert property (
        @(posedge clk) disable iff (rst)
        allocEn |=> tailTag == $past(tailTag) + 1'b1
    ) else $error("tail did not advance after a grant");

endmodule

/* hdl/robCore.sv */
`include "rob_settings.svh"

module robCore (
    input  logic               clk,
    input  logic               rst,
    // from dispatch
    input  logic               allocEn,
    input  logic               allocIsStore,
    input  logic               allocIsBranch,
    input  robPkg::regName_t   allocRd,
    input  logic               allocPred,
    // execution unit completion
    input  logic               exEn,
    input  robPkg::robTag_t    exTag,
    input  robPkg::data_t      exData,
    input  logic               exTaken,
    input  robPkg::addr_t      exTarget,
    // store buffer completion
    input  logic               sbEn,
    input  robPkg::robTag_t    sbTag,
    input  robPkg::data_t      sbData,
    // from commit
    input  logic               retire,
    input  logic               flushNow,
    output logic               full,
    output robPkg::robTag_t    tailTag,
    output logic               headValid,
    output logic               headDone,
    output robPkg::robTag_t    headTag,
    output logic               headIsStore,
    output logic               headIsBranch,
    output robPkg::regName_t   headRd,
    output robPkg::data_t      headData,
    output logic               headPred,
    output logic               headTaken,
    output robPkg::addr_t      headTarget
);
    import robPkg::*;

    localparam int CNT_W = `ROB_TAG_W + 1;

    logic [`ROB_DEPTH-1:0] occupied;
    logic [`ROB_DEPTH-1:0] done;
    logic [`ROB_DEPTH-1:0] entIsStore;
    logic [`ROB_DEPTH-1:0] entIsBranch;
    logic [`ROB_DEPTH-1:0] entPred;
    logic [`ROB_DEPTH-1:0] entTaken;
    regName_t entRd [`ROB_DEPTH];
    data_t entData [`ROB_DEPTH];
    addr_t entTarget [`ROB_DEPTH];

    robTag_t head;
    robTag_t tail;
    logic [CNT_W-1:0] count;

    logic exHit;
    logic sbHit;

    // stale tags (unallocated or flushed) are dropped here
    assign exHit = exEn && occupied[exTag];
    assign sbHit = sbEn && occupied[sbTag];

    assign full = (count == `ROB_DEPTH);
    assign tailTag = tail;

    // head entry view for commit
    assign headValid = occupied[head];
    assign headDone = done[head];
    assign headTag = head;
    assign headIsStore = entIsStore[head];
    assign headIsBranch = entIsBranch[head];
    assign headRd = entRd[head];
    assign headData = entData[head];
    assign headPred = entPred[head];
    assign headTaken = entTaken[head];
    assign headTarget = entTarget[head];

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= '0;
            done <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else if (flushNow) begin
            occupied <= '0; // whole buffer goes away
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (exHit) begin
                done[exTag] <= 1'b1;
            end
            if (sbHit) begin
                done[sbTag] <= 1'b1;
            end
            if (retire) begin
                occupied[head] <= 1'b0;
                head <= head + 1'b1; // wraps at depth
            end
            if (allocEn) begin
                occupied[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            case ({allocEn, retire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (allocEn) begin
            entIsStore[tail] <= allocIsStore;
            entIsBranch[tail] <= allocIsBranch;
            entRd[tail] <= allocRd;
            entPred[tail] <= allocPred;
        end
        if (exHit) begin
            entData[exTag] <= exData;
            entTaken[exTag] <= exTaken;
            entTarget[exTag] <= exTarget;
        end
        if (sbHit) begin
            entData[sbTag] <= sbData;
        end
    end

    retireOnlyDone: assert property (
        @(posedge clk) disable iff (rst)
        retire |-> (headValid && headDone)
    ) else $error("retire while head not done");

    noTagCollision: assert property (
        @(posedge clk) disable iff (rst)
        (exEn && sbEn) |-> (exTag != sbTag)
    ) else $error("exEn and sbEn name the same tag");

    countBound: assert property (
        @(posedge clk) disable iff (rst)
        count <= `ROB_DEPTH
    ) else $error("occupancy count above depth");

endmodule

/* hdl/robCommit.sv */
module robCommit (
    input  logic               clk,
    input  logic               rst,
    input  logic               headValid,
    input  logic               headDone,
    input  robPkg::robTag_t    headTag,
    input  logic               headIsStore,
    input  logic               headIsBranch,
    input  robPkg::regName_t   headRd,
    input  robPkg::data_t      headData,
    input  logic               headPred,
    input  logic               headTaken,
    input  robPkg::addr_t      headTarget,
    output logic               retire,
    output logic               flushNow,
    output logic               rfWe,
    output robPkg::regName_t   rfRd,
    output robPkg::data_t      rfData,
    output robPkg::robTag_t    rfTag,
    output logic               storeCommit,
    output robPkg::robTag_t    storeTag,
    output logic               flush,
    output robPkg::addr_t      redirectPc
);

    logic mispredict;
    logic writesReg;

    // at most one retirement per cycle, always the head
    assign retire = headValid && headDone;
    assign mispredict = headIsBranch && (headTaken != headPred);
    assign flushNow = retire && mispredict;

    // rd of zero means no register result
    assign writesReg = (headRd != '0);

    // strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            rfWe <= 1'b0;
            storeCommit <= 1'b0;
            flush <= 1'b0;
        end else begin
            rfWe <= retire && writesReg;
            storeCommit <= retire && headIsStore;
            flush <= flushNow;
        end
    end

    // payload follows the retired head
    always_ff @(posedge clk) begin
        if (retire) begin
            rfRd <= headRd;
            rfData <= headData; // link value for jal/jalr
            rfTag <= headTag;
            storeTag <= headTag;
        end
        if (flushNow) begin
            redirectPc <= headTarget;
        end
    end

    commitExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(storeCommit && rfWe)
    ) else $error("storeCommit and rfWe high together");

endmodule

/* hdl/robTop.sv */
`include "rob_settings.svh"

module robTop (
    input  logic               clk,
    input  logic               rst,
    // dispatch
    input  logic               dispReq,
    input  logic [`OPC_W-1:0]  dispOpcode,
    input  robPkg::regName_t   dispRd,
    input  logic               dispPredTaken,
    output logic               dispOk,
    output robPkg::robTag_t    dispTag,
    // completions
    input  logic               exEn,
    input  robPkg::robTag_t    exTag,
    input  robPkg::data_t      exData,
    input  logic               exTaken,
    input  robPkg::addr_t      exTarget,
    input  logic               sbEn,
    input  robPkg::robTag_t    sbTag,
    input  robPkg::data_t      sbData,
    // commit
    output logic               rfWe,
    output robPkg::regName_t   rfRd,
    output robPkg::data_t      rfData,
    output robPkg::robTag_t    rfTag,
    output logic               storeCommit,
    output robPkg::robTag_t    storeTag,
    output logic               flush,
    output robPkg::addr_t      redirectPc
);
    import robPkg::*;

    logic allocEn;
    logic allocIsStore;
    logic allocIsBranch;
    regName_t allocRd;
    logic allocPred;
    logic full;
    robTag_t tailTag;

    logic headValid;
    logic headDone;
    robTag_t headTag;
    logic headIsStore;
    logic headIsBranch;
    regName_t headRd;
    data_t headData;
    logic headPred;
    logic headTaken;
    addr_t headTarget;
    logic retire;
    logic flushNow;

    robDispatch iDispatch (
        .clk(clk),
        .rst(rst),
        .dispReq(dispReq),
        .dispOpcode(dispOpcode),
        .dispRd(dispRd),
        .dispPredTaken(dispPredTaken),
        .full(full),
        .flushNow(flushNow),
        .tailTag(tailTag),
        .dispOk(dispOk),
        .dispTag(dispTag),
        .allocEn(allocEn),
        .allocIsStore(allocIsStore),
        .allocIsBranch(allocIsBranch),
        .allocRd(allocRd),
        .allocPred(allocPred)
    );

    robCore iCore (
        .clk(clk),
        .rst(rst),
        .allocEn(allocEn),
        .allocIsStore(allocIsStore),
        .allocIsBranch(allocIsBranch),
        .allocRd(allocRd),
        .allocPred(allocPred),
        .exEn(exEn),
        .exTag(exTag),
        .exData(exData),
        .exTaken(exTaken),
        .exTarget(exTarget),
        .sbEn(sbEn),
        .sbTag(sbTag),
        .sbData(sbData),
        .retire(retire),
        .flushNow(flushNow),
        .full(full),
        .tailTag(tailTag),
        .headValid(headValid),
        .headDone(headDone),
        .headTag(headTag),
        .headIsStore(headIsStore),
        .headIsBranch(headIsBranch),
        .headRd(headRd),
        .headData(headData),
        .headPred(headPred),
        .headTaken(headTaken),
        .headTarget(headTarget)
    );

    robCommit iCommit (
        .clk(clk),
        .rst(rst),
        .headValid(headValid),
        .headDone(headDone),
        .headTag(headTag),
        .headIsStore(headIsStore),
        .headIsBranch(headIsBranch),
        .headRd(headRd),
        .headData(headData),
        .headPred(headPred),
        .headTaken(headTaken),
        .headTarget(headTarget),
        .retire(retire),
        .flushNow(flushNow),
        .rfWe(rfWe),
        .rfRd(rfRd),
        .rfData(rfData),
        .rfTag(rfTag),
        .storeCommit(storeCommit),
        .storeTag(storeTag),
        .flush(flush),
        .redirectPc(redirectPc)
    );

endmodule

/* dv/robTbChecks.sv */
`include "rob_settings.svh"

module robTbChecks (
    input  logic               clk,
    input  logic               rst,
    input  logic               dispReq,
    input  logic [`OPC_W-1:0]  dispOpcode,
    input  robPkg::regName_t   dispRd,
    input  logic               dispPredTaken,
    input  logic               dispOk,
    input  robPkg::robTag_t    dispTag,
    input  logic               exEn,
    input  robPkg::robTag_t    exTag,
    input  robPkg::data_t      exData,
    input  logic               exTaken,
    input  robPkg::addr_t      exTarget,
    input  logic               sbEn,
    input  robPkg::robTag_t    sbTag,
    input  robPkg::data_t      sbData,
    input  logic               rfWe,
    input  robPkg::regName_t   rfRd,
    input  robPkg::data_t      rfData,
    input  robPkg::robTag_t    rfTag,
    input  logic               storeCommit,
    input  robPkg::robTag_t    storeTag,
    input  logic               flush,
    input  robPkg::addr_t      redirectPc,
    output int                 errCount,
    output int                 pending
);
    timeunit 1ns;
    timeprecision 100ps;
    import robPkg::*;

    // reference record of every granted tag
    logic [`ROB_DEPTH-1:0] mOcc, mDone, mStore, mBranch, mPred, mTaken;
    regName_t mRd [`ROB_DEPTH];
    data_t mData [`ROB_DEPTH];
    addr_t mTarget [`ROB_DEPTH];
    robTag_t mHead, mTail;
    int mCount;

    logic mRetire, mFlushNow, expDispOk, modelRdKeep;
    logic expRfWe, expStore, expFlush;
    regName_t expRd;
    data_t expData;
    robTag_t expTag;
    addr_t expPc;

    assign mRetire = mOcc[mHead] && mDone[mHead]; // oldest record finished
    assign mFlushNow = mRetire && mBranch[mHead] && (mTaken[mHead] != mPred[mHead]);
    assign expDispOk = dispReq && (mCount < `ROB_DEPTH) && !mFlushNow;
    assign modelRdKeep = (dispOpcode != OP_STORE) && (dispOpcode != OP_BRANCH);
    assign pending = mCount;

    initial errCount = 0;

    task automatic mismatch(input string sig, input logic [31:0] exp, input logic [31:0] got);
        $display("MISMATCH t=%0t %s expected %h observed %h", $time, sig, exp, got);
        errCount++;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            mOcc <= '0;
            mDone <= '0;
            mHead <= '0;
            mTail <= '0;
            mCount <= 0;
            expRfWe <= 1'b0;
            expStore <= 1'b0;
            expFlush <= 1'b0;
        end else begin
            expRfWe <= mRetire && !mStore[mHead] && (mRd[mHead] != '0);
            expStore <= mRetire && mStore[mHead];
            expFlush <= mFlushNow;
            if (mRetire) begin
                expRd <= mRd[mHead];
                expData <= mData[mHead];
                expTag <= mHead;
            end
            if (mFlushNow) begin
                expPc <= mTarget[mHead];
                mOcc <= '0; // younger records dropped
                mHead <= '0;
                mTail <= '0;
                mCount <= 0;
            end else begin
                if (exEn && mOcc[exTag]) begin
                    mDone[exTag] <= 1'b1;
                    mData[exTag] <= exData;
                    mTaken[exTag] <= exTaken;
                    mTarget[exTag] <= exTarget;
                end
                if (sbEn && mOcc[sbTag]) begin
                    mDone[sbTag] <= 1'b1;
                    mData[sbTag] <= sbData;
                end
                if (mRetire) begin
                    mOcc[mHead] <= 1'b0;
                    mHead <= mHead + 1'b1;
                end
                if (expDispOk) begin
                    mOcc[mTail] <= 1'b1;
                    mDone[mTail] <= 1'b0;
                    mStore[mTail] <= (dispOpcode == OP_STORE);
                    mBranch[mTail] <= (dispOpcode == OP_BRANCH) || (dispOpcode == OP_JAL)
                        || (dispOpcode == OP_JALR);
                    mRd[mTail] <= modelRdKeep ? dispRd : '0;
                    mPred[mTail] <= dispPredTaken;
                    mTail <= mTail + 1'b1;
                end
                mCount <= mCount + int'(expDispOk) - int'(mRetire);
            end
        end
    end

    chkDispOk: assert property (@(posedge clk) disable iff (rst) dispOk == expDispOk)
        else mismatch("dispOk", 32'($sampled(expDispOk)), 32'($sampled(dispOk)));
    chkDispTag: assert property (@(posedge clk) disable iff (rst) dispOk |-> dispTag == mTail)
        else mismatch("dispTag", 32'($sampled(mTail)), 32'($sampled(dispTag)));
    chkRfWe: assert property (@(posedge clk) disable iff (rst) rfWe == expRfWe)
        else mismatch("rfWe", 32'($sampled(expRfWe)), 32'($sampled(rfWe)));
    chkRfRd: assert property (@(posedge clk) disable iff (rst) rfWe |-> rfRd == expRd)
        else mismatch("rfRd", 32'($sampled(expRd)), 32'($sampled(rfRd)));
    chkRfData: assert property (@(posedge clk) disable iff (rst) rfWe |-> rfData == expData)
        else mismatch("rfData", $sampled(expData), $sampled(rfData));
    chkRfTag: assert property (@(posedge clk) disable iff (rst) rfWe |-> rfTag == expTag)
        else mismatch("rfTag", 32'($sampled(expTag)), 32'($sampled(rfTag)));
    chkStore: assert property (@(posedge clk) disable iff (rst) storeCommit == expStore)
        else mismatch("storeCommit", 32'($sampled(expStore)), 32'($sampled(storeCommit)));
    chkStoreTag: assert property (@(posedge clk) disable iff (rst)
        storeCommit |-> storeTag == expTag)
        else mismatch("storeTag", 32'($sampled(expTag)), 32'($sampled(storeTag)));
    chkFlush: assert property (@(posedge clk) disable iff (rst) flush == expFlush)
        else mismatch("flush", 32'($sampled(expFlush)), 32'($sampled(flush)));
    chkPc: assert property (@(posedge clk) disable iff (rst) flush |-> redirectPc == expPc)
        else mismatch("redirectPc", $sampled(expPc), $sampled(redirectPc));

endmodule

/* dv/robTb.sv */
`include "rob_settings.svh"

module robTb;
    timeunit 1ns;
    timeprecision 100ps;
    import robPkg::*;

    localparam logic [`OPC_W-1:0] OP_ALU = 7'b0110011;
    localparam int SEED = 50;
    localparam int TEST_CYCLES = 60 + 300 + 400 + 100 + 200 + 2500; // per-test budgets
    localparam int STRESS_ENTRIES = 100;

    logic clk, rst, dispReq, dispPredTaken, dispOk, exEn, exTaken, sbEn;
    logic rfWe, storeCommit, flush;
    logic [`OPC_W-1:0] dispOpcode;
    regName_t dispRd, rfRd;
    robTag_t dispTag, exTag, sbTag, rfTag, storeTag;
    data_t exData, sbData, rfData;
    addr_t exTarget, redirectPc;
    int errCount, pending;

    int unsigned lcgState = SEED;
    int tbErrs = 0, testsPassed = 0, testsFailed = 0, errStart;
    logic tagStore [`ROB_DEPTH];
    logic tagPred [`ROB_DEPTH];
    robTag_t batch [$];

    robTop i_robTop (.*);
    robTbChecks checks (.*);

    always #20 clk = ~clk;

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic dispatchOne(input logic [`OPC_W-1:0] opc, input regName_t rd,
                               input logic pred);
        robTag_t tag;
        dispReq = 1'b1;
        dispOpcode = opc;
        dispRd = rd;
        dispPredTaken = pred;
        #1;
        while (!dispOk) begin // full or flushing
            tick();
            #1;
        end
        tag = dispTag;
        tagStore[tag] = (opc == OP_STORE);
        tagPred[tag] = pred;
        batch.push_back(tag);
        tick();
        dispReq = 1'b0;
    endtask

    task automatic completeEx(input robTag_t tag, input logic taken, input addr_t target);
        exEn = 1'b1;
        exTag = tag;
        exData = nextRand() ^ (nextRand() << 16);
        exTaken = taken;
        exTarget = target;
        tick();
        exEn = 1'b0;
    endtask

    task automatic completeSb(input robTag_t tag);
        sbEn = 1'b1;
        sbTag = tag;
        sbData = nextRand() ^ (nextRand() << 16);
        tick();
        sbEn = 1'b0;
    endtask

    // finish the recorded batch in random order, branches predicted right
    task automatic completeBatch();
        robTag_t t;
        int j;
        for (int i = batch.size() - 1; i > 0; i--) begin
            j = nextRand() % (i + 1);
            t = batch[i];
            batch[i] = batch[j];
            batch[j] = t;
        end
        while (batch.size() > 0) begin
            t = batch.pop_front();
            if (tagStore[t]) completeSb(t);
            else completeEx(t, tagPred[t], nextRand() << 2);
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (pending != 0 && n < 200) begin
            tick();
            n++;
        end
        if (pending != 0) begin
            $display("buffer did not drain within 200 cycles");
            tbErrs++;
        end
        repeat (2) tick(); // let the last commit pulse be checked
    endtask

    task automatic endTest(input string name);
        if (errCount + tbErrs == errStart) begin
            testsPassed++;
            $display("test %s: pass", name);
        end else begin
            testsFailed++;
            $display("test %s: fail", name);
        end
        errStart = errCount + tbErrs;
    endtask

    initial begin
        #((TEST_CYCLES + 200) * 40);
        $display("watchdog expired, the run did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        robTag_t first, br, a1, a2;
        int kind;
        clk = 0;
        rst = 1;
        {dispReq, dispPredTaken, exEn, exTaken, sbEn} = '0;
        dispOpcode = OP_ALU;
        {dispRd, exTag, sbTag} = '0;
        {exData, sbData, exTarget} = '0;
        repeat (2) @(posedge clk);
        #5;
        rst = 0;
        errStart = 0;

        tick(); // outputs checked low, first tag checked 0
        dispatchOne(OP_ALU, 5'd1, 1'b0);
        completeBatch();
        drain();
        endTest("reset");

        for (int i = 0; i < 8; i++) dispatchOne(OP_ALU, (i == 3) ? 5'd0 : 5'(nextRand()), 0);
        completeBatch();
        drain();
        endTest("out-of-order completion");

        for (int i = 0; i < `ROB_DEPTH; i++) dispatchOne(OP_ALU, 5'(nextRand() | 1), 0);
        first = batch.pop_front();
        dispReq = 1'b1; // held while full
        repeat (3) tick();
        completeEx(first, 1'b0, '0);
        dispatchOne(OP_ALU, 5'd7, 1'b0); // wraps onto the freed slot
        completeBatch();
        drain();
        endTest("full buffer");

        dispatchOne(OP_STORE, 5'd9, 1'b0);
        completeBatch();
        dispatchOne(OP_ALU, 5'd4, 1'b0);
        dispatchOne(OP_STORE, 5'd0, 1'b0);
        exEn = 1'b1;
        exTag = batch[0];
        exData = nextRand();
        sbEn = 1'b1;
        sbTag = batch[1];
        sbData = nextRand();
        tick();
        {exEn, sbEn} = '0;
        batch.delete();
        drain();
        endTest("stores");

        dispatchOne(OP_BRANCH, 5'd0, 1'b0);
        dispatchOne(OP_ALU, 5'd2, 1'b0);
        dispatchOne(OP_ALU, 5'd3, 1'b0);
        br = batch[0];
        a1 = batch[1];
        a2 = batch[2];
        batch.delete();
        completeEx(a2, 1'b0, '0);
        completeEx(a1, 1'b0, '0);
        completeEx(br, 1'b1, 32'h1000_0040); // mispredicted
        drain();
        completeEx(a1, 1'b0, '0); // stale tag
        dispatchOne(OP_ALU, 5'd5, 1'b0); // tag 0 again
        dispatchOne(OP_JAL, 5'd1, 1'b1);
        completeBatch();
        drain();
        endTest("mispredict flush");

        for (int n = 0; n < STRESS_ENTRIES; ) begin
            for (int k = 1 + nextRand() % 8; k > 0 && n < STRESS_ENTRIES; k--) begin
                kind = nextRand() % 4;
                dispatchOne((kind == 0) ? OP_STORE : (kind == 1) ? OP_BRANCH :
                            (kind == 2) ? OP_JAL : OP_ALU, 5'(nextRand()), nextRand() % 2);
                n++;
            end
            completeBatch();
        end
        drain();
        endTest("wraparound stress");

        $display("tests passed %0d, failed %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errCount == 0 && tbErrs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hdl
hdl/robPkg.sv
hdl/robDispatch.sv
hdl/robCore.sv
hdl/robCommit.sv
hdl/robTop.sv
dv/robTbChecks.sv
dv/robTb.sv

/* Makefile */
# Verilator build and run of the reorder buffer testbench

VERILATOR ?= verilator
TOP       ?= robTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := ALL TESTS PASSED

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

test: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "make test: pass"; \
	else \
		echo "make test: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
